// File: axi_lite_port.sv
`timescale 1ns/1ns
`default_nettype none

module axi_lite_port (
    input  wire         S_AXI_ACLK,
    input  wire         cache_slv_reg0,
    // Write address and data
    input  wire [cpu_core_ctrl_pkg::ADDR_W-1:0] S_AXI_AWADDR,
    input  wire         S_AXI_AWVALID,
    output logic        S_AXI_AWREADY,
    input  wire [cpu_core_ctrl_pkg::DATA_W-1:0] S_AXI_WDATA,
    input  wire         S_AXI_WVALID,
    output logic        S_AXI_WREADY,
    // Write response
    output logic [1:0]  S_AXI_BRESP,
    output logic        S_AXI_BVALID,
    input  wire         S_AXI_BREADY,
    // Read address and data
    input  wire [cpu_core_ctrl_pkg::ADDR_W-1:0] S_AXI_ARADDR,
    input  wire         S_AXI_ARVALID,
    output logic        S_AXI_ARREADY,
    output logic [cpu_core_ctrl_pkg::DATA_W-1:0] S_AXI_RDATA,
    output logic [1:0]  S_AXI_RRESP,
    output logic        S_AXI_RVALID,
    input  wire         S_AXI_RREADY,
    // Register side
    output logic        wr_strobe,
    output cpu_core_ctrl_pkg::core_addr_u wr_addr,
    output logic [cpu_core_ctrl_pkg::DATA_W-1:0] wr_data,
    output logic        rd_strobe,
    output cpu_core_ctrl_pkg::core_addr_u rd_addr,
    input  wire [cpu_core_ctrl_pkg::DATA_W-1:0] rd_data
);

    logic                                wr_ready;
    logic                                wr_pending;
    logic                                bvalid_q;
    logic                                rd_ready;
    logic                                rvalid_q;
    logic [cpu_core_ctrl_pkg::DATA_W-1:0] rdata_q;
    logic                                wr_accept;
    logic                                rd_accept;

    // ------------------------------------------------------------------
    // Write channels
    // ------------------------------------------------------------------
    // Address and data must arrive together, one write in flight
    assign wr_accept = S_AXI_AWVALID && S_AXI_WVALID && !wr_pending;

    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
        begin
            wr_ready   <= 1'b0;
            wr_pending <= 1'b0;
            bvalid_q   <= 1'b0;
        end
        else
        begin
            // Single-cycle ready pulse on both channels
            wr_ready <= wr_accept;
            // Held until the response is taken
            if (wr_accept)
                wr_pending <= 1'b1;
            else if (bvalid_q && S_AXI_BREADY)
                wr_pending <= 1'b0;
            // Response follows the ready pulse
            if (wr_ready)
                bvalid_q <= 1'b1;
            else if (S_AXI_BREADY)
                bvalid_q <= 1'b0;
        end
    end

    // Address and data captured when the write is taken
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (wr_accept)
        begin
            wr_addr.raw <= S_AXI_AWADDR;
            wr_data     <= S_AXI_WDATA;
        end
    end

    // ------------------------------------------------------------------
    // Read channels
    // ------------------------------------------------------------------
    // Blocked while a read response is still waiting
    assign rd_accept = S_AXI_ARVALID && !rd_ready && !rvalid_q;

    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
        begin
            rd_ready <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            rd_ready <= rd_accept;
            if (rd_ready)
                rvalid_q <= 1'b1;
            else if (S_AXI_RREADY)
                rvalid_q <= 1'b0;
        end
    end

    // Read address latch, then the decoded word on the ready cycle
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_accept)
            rd_addr.raw <= S_AXI_ARADDR;
        if (rd_ready)
            rdata_q <= rd_data;
    end

    // Outputs
    assign S_AXI_AWREADY = wr_ready;
    assign S_AXI_WREADY  = wr_ready;
    assign S_AXI_BVALID  = bvalid_q;
    assign S_AXI_BRESP   = cpu_core_ctrl_pkg::RESP_OKAY;
    assign S_AXI_ARREADY = rd_ready;
    assign S_AXI_RVALID  = rvalid_q;
    assign S_AXI_RDATA   = rdata_q;
    assign S_AXI_RRESP   = cpu_core_ctrl_pkg::RESP_OKAY;
    // Strobes coincide with the ready pulses
    assign wr_strobe     = wr_ready;
    assign rd_strobe     = rd_ready;

endmodule

`default_nettype wire

// File: core_ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module core_ctrl_regs (
    input  wire         S_AXI_ACLK,
    input  wire         cache_slv_reg0,
    input  wire         wr_strobe,
    input  wire cpu_core_ctrl_pkg::core_addr_u wr_addr,
    input  wire [cpu_core_ctrl_pkg::DATA_W-1:0] wr_data,
    output logic [cpu_core_ctrl_pkg::DATA_W-1:0] exec_level_word,
    output logic        core_rst,
    output logic        core_rst_n,
    output logic        core_exec
);

    logic       ctrl_hit;
    logic       data_nz;
    logic       rst_hit;
    logic       level_hit;
    logic       pulse_hit;
    logic       pulse_req;
    logic [4:0] rst_cnt;

    // ------------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------------
    // Word-aligned access in the low control page
    assign ctrl_hit  = wr_strobe && (wr_addr.ctrl.upper == '0)
                       && (wr_addr.ctrl.byte_ofs == '0);
    assign data_nz   = (wr_data != '0);
    assign rst_hit   = ctrl_hit && data_nz
                       && (wr_addr.ctrl.word == cpu_core_ctrl_pkg::OFS_CORE_RST[3:2]);
    assign level_hit = ctrl_hit
                       && (wr_addr.ctrl.word == cpu_core_ctrl_pkg::OFS_EXEC_LEVEL[3:2]);
    assign pulse_hit = ctrl_hit && data_nz
                       && (wr_addr.ctrl.word == cpu_core_ctrl_pkg::OFS_EXEC_PULSE[3:2]);

    // Level word store and pulse request
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
        begin
            exec_level_word <= '0;
            pulse_req       <= 1'b0;
        end
        else
        begin
            if (level_hit)
                exec_level_word <= wr_data;
            pulse_req <= pulse_hit;
        end
    end

    // ------------------------------------------------------------------
    // Reset sequencer
    // ------------------------------------------------------------------
    // A request reloads the count, core_rst follows one cycle later
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
        begin
            rst_cnt    <= 5'd1;
            core_rst   <= 1'b1;
            core_rst_n <= 1'b0;
        end
        else if (rst_hit)
            rst_cnt <= 5'd1;
        else if (rst_cnt == cpu_core_ctrl_pkg::RST_LEN)
        begin
            // End of sequence, counter parks at zero
            rst_cnt    <= 5'd0;
            core_rst   <= 1'b0;
            core_rst_n <= 1'b1;
        end
        else if (rst_cnt != 5'd0)
        begin
            rst_cnt    <= rst_cnt + 5'd1;
            core_rst   <= 1'b1;
            core_rst_n <= 1'b0;
        end
    end

    // Execute level or one-cycle pulse
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
            core_exec <= 1'b0;
        else
            core_exec <= (exec_level_word != '0) || pulse_req;
    end

endmodule

`default_nettype wire

// File: core_read_mux.sv
`timescale 1ns/1ns
`default_nettype none

module core_read_mux (
    input  wire S_AXI_ACLK,
    input  wire [cpu_core_ctrl_pkg::DATA_W-1:0] core_pc,
    input  wire cpu_core_ctrl_pkg::rd_region_e rd_region,
    input  wire [cpu_core_ctrl_pkg::SLICE_W-1:0] slice_sel,
    input  wire [cpu_core_ctrl_pkg::NUM_SLICES-1:0][cpu_core_ctrl_pkg::DATA_W-1:0] slice_word,
    input  wire [cpu_core_ctrl_pkg::DATA_W-1:0] exec_level_word,
    output logic [cpu_core_ctrl_pkg::DATA_W-1:0] rd_data
);

    logic [cpu_core_ctrl_pkg::DATA_W-1:0] pc_s0;
    logic [cpu_core_ctrl_pkg::DATA_W-1:0] pc_s1;

    // ------------------------------------------------------------------
    // Program counter sampling
    // ------------------------------------------------------------------
    // Same two-stage latency as the GPR slices
    always_ff @(posedge S_AXI_ACLK)
    begin
        pc_s0 <= core_pc;
        pc_s1 <= pc_s0;
    end

    // ------------------------------------------------------------------
    // Final read data
    // ------------------------------------------------------------------
    always_comb
    begin
        case (rd_region)
            cpu_core_ctrl_pkg::RD_CTRL:
                rd_data = exec_level_word;
            cpu_core_ctrl_pkg::RD_GPR:
                rd_data = slice_word[slice_sel];
            cpu_core_ctrl_pkg::RD_PC:
                rd_data = pc_s1;
            // Unmapped space reads zero
            default:
                rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: core_reg_slice.sv
`timescale 1ns/1ns
`default_nettype none

module core_reg_slice (
    input  wire S_AXI_ACLK,
    input  wire [cpu_core_ctrl_pkg::GPRS_PER_SLICE-1:0][cpu_core_ctrl_pkg::DATA_W-1:0] gpr_in,
    input  wire [cpu_core_ctrl_pkg::IDX_W-1:0] slice_idx,
    output logic [cpu_core_ctrl_pkg::DATA_W-1:0] slice_word
);

    // ------------------------------------------------------------------
    // Two sampling stages for the core register values
    // ------------------------------------------------------------------
    logic [cpu_core_ctrl_pkg::GPRS_PER_SLICE-1:0][cpu_core_ctrl_pkg::DATA_W-1:0] stage0;
    logic [cpu_core_ctrl_pkg::GPRS_PER_SLICE-1:0][cpu_core_ctrl_pkg::DATA_W-1:0] stage1;

    // Plain data pipeline
    always_ff @(posedge S_AXI_ACLK)
    begin
        stage0 <= gpr_in;
        stage1 <= stage0;
    end

    // Word selected by the decoded index
    assign slice_word = stage1[slice_idx];

endmodule

`default_nettype wire

// File: core_reg_window_decode.sv
`timescale 1ns/1ns
`default_nettype none

module core_reg_window_decode (
    input  wire cpu_core_ctrl_pkg::core_addr_u rd_addr,
    output cpu_core_ctrl_pkg::rd_region_e rd_region,
    output logic [cpu_core_ctrl_pkg::SLICE_W-1:0] slice_sel,
    output logic [cpu_core_ctrl_pkg::IDX_W-1:0]   slice_idx
);

    logic ctrl_word;
    logic win_word;

    // Only the execute level word reads back from the control page
    assign ctrl_word = (rd_addr.ctrl.upper == '0) && (rd_addr.ctrl.byte_ofs == '0)
                       && (rd_addr.ctrl.word == cpu_core_ctrl_pkg::OFS_EXEC_LEVEL[3:2]);
    // Aligned word inside the 0x1000 window
    assign win_word  = (rd_addr.win.region == cpu_core_ctrl_pkg::WIN_REGION)
                       && (rd_addr.win.unused == '0) && (rd_addr.win.byte_ofs == '0);

    always_comb
    begin
        rd_region = cpu_core_ctrl_pkg::RD_NONE;
        if (ctrl_word)
            rd_region = cpu_core_ctrl_pkg::RD_CTRL;
        else if (win_word && (rd_addr.win.word < cpu_core_ctrl_pkg::NUM_GPR))
            rd_region = cpu_core_ctrl_pkg::RD_GPR;
        else if (win_word && (rd_addr.win.word == cpu_core_ctrl_pkg::PC_WORD))
            rd_region = cpu_core_ctrl_pkg::RD_PC;
    end

    // Upper bits pick the slice, lower bits the register inside it
    assign slice_sel = rd_addr.win.word[cpu_core_ctrl_pkg::IDX_W +: cpu_core_ctrl_pkg::SLICE_W];
    assign slice_idx = rd_addr.win.word[cpu_core_ctrl_pkg::IDX_W-1:0];

endmodule

`default_nettype wire

// File: cpu_core_ctrl_pkg.sv
`default_nettype none

package cpu_core_ctrl_pkg;

    // ------------------------------------------------------------------
    // Sizes and counts
    // ------------------------------------------------------------------
    // Bus and core register word
    localparam int DATA_W         = 32;
    localparam int ADDR_W         = 16;
    // Core general registers, split across slices of eight
    localparam int NUM_GPR        = 32;
    localparam int GPRS_PER_SLICE = 8;
    localparam int NUM_SLICES     = 4;
    localparam int IDX_W          = 3;
    localparam int SLICE_W        = 2;

    // ------------------------------------------------------------------
    // Control register offsets
    // ------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] OFS_CORE_RST   = 16'h0000;
    localparam logic [ADDR_W-1:0] OFS_EXEC_LEVEL = 16'h0004;
    localparam logic [ADDR_W-1:0] OFS_EXEC_PULSE = 16'h0008;

    // Core register window at 0x1000, PC right after the GPRs
    localparam logic [3:0] WIN_REGION = 4'd1;
    localparam logic [6:0] PC_WORD    = 7'd32;

    // Reset sequencer end count and bus response
    localparam logic [4:0] RST_LEN   = 5'd31;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Bus address, decoded as a control word on writes
    // and as a register window word on reads
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [11:0] upper;
            logic [1:0]  word;
            logic [1:0]  byte_ofs;
        } ctrl;
        struct packed {
            logic [3:0] region;
            logic [2:0] unused;
            logic [6:0] word;
            logic [1:0] byte_ofs;
        } win;
    } core_addr_u;

    // Read target of the latched read address
    typedef enum logic [1:0] {
        RD_NONE = 2'd0,
        RD_CTRL = 2'd1,
        RD_GPR  = 2'd2,
        RD_PC   = 2'd3
    } rd_region_e;

endpackage

`default_nettype wire

// File: cpu_core_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_ctrl_top (
    input  wire         S_AXI_ACLK,
    input  wire         cache_slv_reg0,
    // AXI4-Lite write channels
    input  wire [15:0]  S_AXI_AWADDR,
    input  wire         S_AXI_AWVALID,
    output logic        S_AXI_AWREADY,
    input  wire [31:0]  S_AXI_WDATA,
    input  wire         S_AXI_WVALID,
    output logic        S_AXI_WREADY,
    output logic [1:0]  S_AXI_BRESP,
    output logic        S_AXI_BVALID,
    input  wire         S_AXI_BREADY,
    // AXI4-Lite read channels
    input  wire [15:0]  S_AXI_ARADDR,
    input  wire         S_AXI_ARVALID,
    output logic        S_AXI_ARREADY,
    output logic [31:0] S_AXI_RDATA,
    output logic [1:0]  S_AXI_RRESP,
    output logic        S_AXI_RVALID,
    input  wire         S_AXI_RREADY,
    // Core side
    input  wire [cpu_core_ctrl_pkg::NUM_GPR-1:0][cpu_core_ctrl_pkg::DATA_W-1:0] core_gpr,
    input  wire [cpu_core_ctrl_pkg::DATA_W-1:0] core_pc,
    output logic        core_rst,
    output logic        core_rst_n,
    output logic        core_exec
);

    // ------------------------------------------------------------------
    // Internal connections
    // ------------------------------------------------------------------
    wire                                  wr_strobe;
    wire cpu_core_ctrl_pkg::core_addr_u   wr_addr;
    wire [cpu_core_ctrl_pkg::DATA_W-1:0]  wr_data;
    wire cpu_core_ctrl_pkg::core_addr_u   rd_addr;
    wire [cpu_core_ctrl_pkg::DATA_W-1:0]  rd_data;
    wire [cpu_core_ctrl_pkg::DATA_W-1:0]  exec_level_word;
    wire cpu_core_ctrl_pkg::rd_region_e   rd_region;
    wire [cpu_core_ctrl_pkg::SLICE_W-1:0] slice_sel;
    wire [cpu_core_ctrl_pkg::IDX_W-1:0]   slice_idx;
    wire [cpu_core_ctrl_pkg::NUM_SLICES-1:0][cpu_core_ctrl_pkg::DATA_W-1:0] slice_word;

    // Bus handshakes
    axi_lite_port u_axi (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .cache_slv_reg0 (cache_slv_reg0),
        .S_AXI_AWADDR   (S_AXI_AWADDR),
        .S_AXI_AWVALID  (S_AXI_AWVALID),
        .S_AXI_AWREADY  (S_AXI_AWREADY),
        .S_AXI_WDATA    (S_AXI_WDATA),
        .S_AXI_WVALID   (S_AXI_WVALID),
        .S_AXI_WREADY   (S_AXI_WREADY),
        .S_AXI_BRESP    (S_AXI_BRESP),
        .S_AXI_BVALID   (S_AXI_BVALID),
        .S_AXI_BREADY   (S_AXI_BREADY),
        .S_AXI_ARADDR   (S_AXI_ARADDR),
        .S_AXI_ARVALID  (S_AXI_ARVALID),
        .S_AXI_ARREADY  (S_AXI_ARREADY),
        .S_AXI_RDATA    (S_AXI_RDATA),
        .S_AXI_RRESP    (S_AXI_RRESP),
        .S_AXI_RVALID   (S_AXI_RVALID),
        .S_AXI_RREADY   (S_AXI_RREADY),
        .wr_strobe      (wr_strobe),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_strobe      (),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data)
    );

    // Control words and core reset / execute
    core_ctrl_regs u_ctrl (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .cache_slv_reg0  (cache_slv_reg0),
        .wr_strobe       (wr_strobe),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .exec_level_word (exec_level_word),
        .core_rst        (core_rst),
        .core_rst_n      (core_rst_n),
        .core_exec       (core_exec)
    );

    core_reg_window_decode u_dec (
        .rd_addr   (rd_addr),
        .rd_region (rd_region),
        .slice_sel (slice_sel),
        .slice_idx (slice_idx)
    );

    // One slice per group of eight GPRs
    genvar s;
    generate
        for (s = 0; s < cpu_core_ctrl_pkg::NUM_SLICES; s = s + 1)
        begin : g_slice
            core_reg_slice u_slice (
                .S_AXI_ACLK (S_AXI_ACLK),
                .gpr_in     (core_gpr[s*cpu_core_ctrl_pkg::GPRS_PER_SLICE +:
                                      cpu_core_ctrl_pkg::GPRS_PER_SLICE]),
                .slice_idx  (slice_idx),
                .slice_word (slice_word[s])
            );
        end
    endgenerate

    core_read_mux u_mux (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .core_pc         (core_pc),
        .rd_region       (rd_region),
        .slice_sel       (slice_sel),
        .slice_word      (slice_word),
        .exec_level_word (exec_level_word),
        .rd_data         (rd_data)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f vlog.f --top-module tb_cpu_core_ctrl -o sim_cpu_core_ctrl
sim_out="$(./obj_dir/sim_cpu_core_ctrl 2>&1 || true)"
echo "$sim_out"
if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// File: tb_cpu_core_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core_ctrl;

    localparam int RST_CYCLES = int'(cpu_core_ctrl_pkg::RST_LEN);
    localparam int WAIT_LIMIT = 100;
    localparam logic [15:0] WIN_BASE = 16'h1000;

    logic        S_AXI_ACLK = 1'b0;
    logic        cache_slv_reg0;
    logic [15:0] S_AXI_AWADDR;
    logic        S_AXI_AWVALID;
    wire         S_AXI_AWREADY;
    logic [31:0] S_AXI_WDATA;
    logic        S_AXI_WVALID;
    wire         S_AXI_WREADY;
    wire  [1:0]  S_AXI_BRESP;
    wire         S_AXI_BVALID;
    logic        S_AXI_BREADY;
    logic [15:0] S_AXI_ARADDR;
    logic        S_AXI_ARVALID;
    wire         S_AXI_ARREADY;
    wire  [31:0] S_AXI_RDATA;
    wire  [1:0]  S_AXI_RRESP;
    wire         S_AXI_RVALID;
    logic        S_AXI_RREADY;
    logic [cpu_core_ctrl_pkg::NUM_GPR-1:0][cpu_core_ctrl_pkg::DATA_W-1:0] core_gpr;
    logic [31:0] core_pc;
    wire         core_rst;
    wire         core_rst_n;
    wire         core_exec;

    // Reference model of the readable words
    logic [31:0] gpr_model [0:31];
    logic [31:0] pc_model    = '0;
    logic [31:0] level_model = '0;
    logic [15:0] unmapped [0:6] = '{16'h0000, 16'h0008, 16'h000C, 16'h1002,
                                    16'h1084, 16'h2000, 16'h8004};

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    cpu_core_ctrl_top dut0 (.*);

    always #5 S_AXI_ACLK = ~S_AXI_ACLK;

    // ------------------------------------------------------------------
    // Edge monitor
    // ------------------------------------------------------------------
    // Values seen at a rising edge were set by the edge before it
    int   cycle           = 0;
    int   strobe_cycle    = 0;
    int   rst_rise_cycle  = 0;
    int   rst_fall_cycle  = 0;
    int   rst_rise_count  = 0;
    int   exec_rise_cycle = 0;
    int   exec_fall_cycle = 0;
    int   exec_high_count = 0;
    logic rst_prev        = 1'b1;
    logic exec_prev       = 1'b0;

    always @(posedge S_AXI_ACLK)
    begin
        // Write strobe coincides with AWREADY
        if (S_AXI_AWREADY === 1'b1)
            strobe_cycle = cycle;
        if (core_rst === 1'b1 && rst_prev === 1'b0)
        begin
            rst_rise_cycle = cycle;
            rst_rise_count = rst_rise_count + 1;
        end
        if (core_rst === 1'b0 && rst_prev === 1'b1)
            rst_fall_cycle = cycle;
        if (core_exec === 1'b1 && exec_prev === 1'b0)
            exec_rise_cycle = cycle;
        if (core_exec === 1'b0 && exec_prev === 1'b1)
            exec_fall_cycle = cycle;
        if (core_exec === 1'b1)
            exec_high_count = exec_high_count + 1;
        rst_prev  = core_rst;
        exec_prev = core_exec;
        cycle     = cycle + 1;
    end

    // ------------------------------------------------------------------
    // Checking and run control
    // ------------------------------------------------------------------
    task automatic finish_run();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic give_up(input string what);
        $display("Timed out waiting for %s", what);
        timeouts = timeouts + 1;
        finish_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        assert (got === exp)
        else
        begin
            errors = errors + 1;
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // Readable words by address map
    function automatic logic [31:0] expected_word(input logic [15:0] addr);
        logic [31:0] value;
        value = '0;
        if (addr == cpu_core_ctrl_pkg::OFS_EXEC_LEVEL)
            value = level_model;
        else if (addr >= WIN_BASE && addr < WIN_BASE + 16'h0080 && addr[1:0] == 2'b00)
            value = gpr_model[addr[6:2]];
        else if (addr == WIN_BASE + 16'h0080)
            value = pc_model;
        return value;
    endfunction

    // ------------------------------------------------------------------
    // Bus tasks entered and left on a falling edge
    // ------------------------------------------------------------------
    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data);
        int n;
        int gap;
        S_AXI_AWADDR  = addr;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WDATA   = data;
        S_AXI_WVALID  = 1'b1;
        n = 0;
        do
        begin
            @(negedge S_AXI_ACLK);
            n = n + 1;
            if (n > WAIT_LIMIT)
                give_up("AWREADY");
        end
        while (S_AXI_AWREADY !== 1'b1);
        check_value("S_AXI_WREADY", {31'd0, S_AXI_WREADY}, 32'd1);
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        n = 0;
        while (S_AXI_BVALID !== 1'b1)
        begin
            @(negedge S_AXI_ACLK);
            n = n + 1;
            if (n > WAIT_LIMIT)
                give_up("BVALID");
        end
        check_value("S_AXI_BRESP", {30'd0, S_AXI_BRESP},
                    {30'd0, cpu_core_ctrl_pkg::RESP_OKAY});
        // Response held back for a few cycles
        gap = $urandom() % 4;
        repeat (gap) @(negedge S_AXI_ACLK);
        S_AXI_BREADY = 1'b1;
        @(negedge S_AXI_ACLK);
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr, output logic [31:0] data);
        int n;
        int gap;
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        n = 0;
        do
        begin
            @(negedge S_AXI_ACLK);
            n = n + 1;
            if (n > WAIT_LIMIT)
                give_up("ARREADY");
        end
        while (S_AXI_ARREADY !== 1'b1);
        S_AXI_ARVALID = 1'b0;
        n = 0;
        while (S_AXI_RVALID !== 1'b1)
        begin
            @(negedge S_AXI_ACLK);
            n = n + 1;
            if (n > WAIT_LIMIT)
                give_up("RVALID");
        end
        data = S_AXI_RDATA;
        check_value("S_AXI_RRESP", {30'd0, S_AXI_RRESP},
                    {30'd0, cpu_core_ctrl_pkg::RESP_OKAY});
        gap = $urandom() % 4;
        repeat (gap) @(negedge S_AXI_ACLK);
        S_AXI_RREADY = 1'b1;
        @(negedge S_AXI_ACLK);
        S_AXI_RREADY = 1'b0;
    endtask

    task automatic expect_read(input logic [15:0] addr);
        logic [31:0] data;
        axi_read(addr, data);
        check_value($sformatf("S_AXI_RDATA at 0x%04h", addr), data, expected_word(addr));
    endtask

    // One more falling edge so the monitor has caught up
    task automatic wait_core_rst(input logic level);
        int n;
        n = 0;
        while (core_rst !== level)
        begin
            @(negedge S_AXI_ACLK);
            n = n + 1;
            if (n > WAIT_LIMIT)
                give_up("core_rst");
        end
        @(negedge S_AXI_ACLK);
    endtask

    task automatic wait_core_exec(input logic level);
        int n;
        n = 0;
        while (core_exec !== level)
        begin
            @(negedge S_AXI_ACLK);
            n = n + 1;
            if (n > WAIT_LIMIT)
                give_up("core_exec");
        end
        @(negedge S_AXI_ACLK);
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial
    begin
        int release_cycle;
        int count_before;
        void'($urandom(89));
        cache_slv_reg0 = 1'b1;
        S_AXI_AWADDR   = '0;
        S_AXI_AWVALID  = 1'b0;
        S_AXI_WDATA    = '0;
        S_AXI_WVALID   = 1'b0;
        S_AXI_BREADY   = 1'b0;
        S_AXI_ARADDR   = '0;
        S_AXI_ARVALID  = 1'b0;
        S_AXI_RREADY   = 1'b0;
        core_gpr       = '0;
        core_pc        = '0;
        for (int i = 0; i < cpu_core_ctrl_pkg::NUM_GPR; i++)
            gpr_model[i[4:0]] = '0;
        repeat (2) @(posedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        cache_slv_reg0 = 1'b0;
        release_cycle  = cycle;

        // Power-up sequence with execute held low
        wait_core_rst(1'b0);
        check_value("core_rst fall cycle", rst_fall_cycle, release_cycle + RST_CYCLES);
        check_value("core_rst_n", {31'd0, core_rst_n}, 32'd1);
        check_value("core_exec high cycles", exec_high_count, 0);

        // Restart by a nonzero write and not by a zero write
        axi_write(cpu_core_ctrl_pkg::OFS_CORE_RST, 32'h1);
        wait_core_rst(1'b1);
        wait_core_rst(1'b0);
        check_value("core_rst rise cycle", rst_rise_cycle, strobe_cycle + 2);
        check_value("core_rst high cycles", rst_fall_cycle - rst_rise_cycle, RST_CYCLES - 1);
        count_before = rst_rise_count;
        axi_write(cpu_core_ctrl_pkg::OFS_CORE_RST, 32'h0);
        repeat (4) @(negedge S_AXI_ACLK);
        check_value("core_rst rise count", rst_rise_count, count_before);

        // Execute level word and its readback
        level_model = $urandom() | 32'h1;
        axi_write(cpu_core_ctrl_pkg::OFS_EXEC_LEVEL, level_model);
        wait_core_exec(1'b1);
        check_value("core_exec rise cycle", exec_rise_cycle, strobe_cycle + 2);
        expect_read(cpu_core_ctrl_pkg::OFS_EXEC_LEVEL);
        level_model = '0;
        axi_write(cpu_core_ctrl_pkg::OFS_EXEC_LEVEL, level_model);
        wait_core_exec(1'b0);
        check_value("core_exec fall cycle", exec_fall_cycle, strobe_cycle + 2);
        expect_read(cpu_core_ctrl_pkg::OFS_EXEC_LEVEL);

        // Single execute pulse
        count_before = exec_high_count;
        axi_write(cpu_core_ctrl_pkg::OFS_EXEC_PULSE, $urandom() | 32'h1);
        repeat (4) @(negedge S_AXI_ACLK);
        check_value("core_exec pulse cycles", exec_high_count - count_before, 1);
        check_value("core_exec pulse cycle", exec_rise_cycle, strobe_cycle + 2);
        count_before = exec_high_count;
        axi_write(cpu_core_ctrl_pkg::OFS_EXEC_PULSE, 32'h0);
        repeat (4) @(negedge S_AXI_ACLK);
        check_value("core_exec pulse cycles", exec_high_count - count_before, 0);

        // Core register window with fresh random values per round
        for (int round = 0; round < 2; round++)
        begin
            for (int i = 0; i < cpu_core_ctrl_pkg::NUM_GPR; i++)
            begin
                gpr_model[i[4:0]] = $urandom();
                core_gpr[i[4:0]]  = gpr_model[i[4:0]];
            end
            pc_model = $urandom();
            core_pc  = pc_model;
            repeat (2) @(negedge S_AXI_ACLK);
            for (int i = 0; i < cpu_core_ctrl_pkg::NUM_GPR; i++)
                expect_read(WIN_BASE + {9'd0, i[4:0], 2'b00});
            expect_read(WIN_BASE + 16'h0080);
            foreach (unmapped[k])
                expect_read(unmapped[k]);
        end

        finish_run();
    end

endmodule

`default_nettype wire

// File: tb_cpu_core_ctrl_sva.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core_ctrl_sva (
    input wire S_AXI_ACLK,
    input wire cache_slv_reg0,
    input wire S_AXI_AWREADY,
    input wire S_AXI_ARREADY,
    input wire S_AXI_BVALID,
    input wire S_AXI_BREADY,
    input wire S_AXI_RVALID,
    input wire S_AXI_RREADY,
    input wire core_rst,
    input wire core_rst_n
);

    localparam logic [5:0] RST_HIGH = 6'(cpu_core_ctrl_pkg::RST_LEN) - 6'd1;

    logic       rst_q;
    logic       restarted;
    logic [5:0] high_len;

    // ------------------------------------------------------------------
    // Length of each core reset pulse after a rise
    // ------------------------------------------------------------------
    // Power-up run is not a rise, only restarts are measured
    always_ff @(posedge S_AXI_ACLK or posedge cache_slv_reg0)
    begin
        if (cache_slv_reg0)
        begin
            rst_q     <= 1'b1;
            restarted <= 1'b0;
            high_len  <= '0;
        end
        else
        begin
            rst_q <= core_rst;
            if (core_rst && !rst_q)
            begin
                restarted <= 1'b1;
                high_len  <= 6'd1;
            end
            else if (core_rst)
                high_len <= high_len + 6'd1;
        end
    end

    a_rst_len : assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        $fell(core_rst) && restarted |-> high_len == RST_HIGH)
        else $error("core_rst pulse length 0x%02h", high_len);

    a_rst_n : assert property (@(posedge S_AXI_ACLK) core_rst_n == !core_rst)
        else $error("core_rst_n is not the inverse of core_rst");

    // Bus protocol
    a_bvalid_hold : assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
        else $error("BVALID dropped before BREADY");

    a_rvalid_hold : assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID)
        else $error("RVALID dropped before RREADY");

    a_awready_pulse : assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        S_AXI_AWREADY |=> !S_AXI_AWREADY)
        else $error("AWREADY high for more than one cycle");

    a_arready_pulse : assert property (@(posedge S_AXI_ACLK) disable iff (cache_slv_reg0)
        S_AXI_ARREADY |=> !S_AXI_ARREADY)
        else $error("ARREADY high for more than one cycle");

endmodule

bind cpu_core_ctrl_top cpu_core_ctrl_sva u_sva (
    .S_AXI_ACLK     (S_AXI_ACLK),
    .cache_slv_reg0 (cache_slv_reg0),
    .S_AXI_AWREADY  (S_AXI_AWREADY),
    .S_AXI_ARREADY  (S_AXI_ARREADY),
    .S_AXI_BVALID   (S_AXI_BVALID),
    .S_AXI_BREADY   (S_AXI_BREADY),
    .S_AXI_RVALID   (S_AXI_RVALID),
    .S_AXI_RREADY   (S_AXI_RREADY),
    .core_rst       (core_rst),
    .core_rst_n     (core_rst_n)
);

`default_nettype wire

// File: vlog.f
cpu_core_ctrl_pkg.sv
axi_lite_port.sv
core_ctrl_regs.sv
core_reg_window_decode.sv
core_reg_slice.sv
core_read_mux.sv
cpu_core_ctrl_top.sv
tb_cpu_core_ctrl_sva.sv
tb_cpu_core_ctrl.sv
